// ==== testbench/fpuAddTrace.txt ====
# kind op rn rm expValue expUnderflow expCancel, all hex
# kind 0 request, 1 control write, 2 status check, 3 drain (rn test id), 4 hold, 5 release
0 1 3FF0000000000000 3FF0000000000000 4000000000000000 0 0
0 2 4000000000000000 3FF0000000000000 3FF0000000000000 0 0
0 1 3FF0000000000000 4000000000000000 4008000000000000 0 0
0 1 3FF0000000000000 3E10000000000000 3FF0000000400000 0 0
0 1 3FF0000000000000 3C30000000000000 3FF0000000000000 0 0
0 1 C008000000000000 3FF0000000000000 C000000000000000 0 0
3 0 1 0 0 0 0
2 0 0 0 0 0 0
0 3 5 0 4014000000000000 0 0
0 3 FFFFFFFFFFFFFFFB 0 C014000000000000 0 0
0 3 3E8 0 408F400000000000 0 0
0 3 0 0 0 0 1
3 0 2 0 0 0 0
2 0 2 2 0 0 0
1 0 0 0 0 0 0
0 1 3FF0000000000000 3CB8000000000000 3FF0000000000001 0 0
3 0 0 0 0 0 0
1 0 1 0 0 0 0
0 1 3FF0000000000000 3CB8000000000000 3FF0000000000002 0 0
3 0 3 0 0 0 0
0 2 3FF0000000000000 3FF0000000000000 0 0 1
3 0 0 0 0 0 0
2 0 2 0 0 0 0
0 1 3FF0000000000000 3FF0000000000000 4000000000000000 0 0
3 0 0 0 0 0 0
2 0 2 2 0 0 0
0 2 0010000000000001 0010000000000000 0 1 0
3 0 0 0 0 0 0
2 0 1 0 0 0 0
0 1 4000000000000000 3FF0000000000000 4008000000000000 0 0
3 0 0 0 0 0 0
2 0 1 1 0 0 0
3 0 4 0 0 0 0
4 0 0 0 0 0 0
0 1 3FF0000000000000 3FF0000000000000 4000000000000000 0 0
0 3 5 0 4014000000000000 0 0
0 2 4000000000000000 3FF0000000000000 3FF0000000000000 0 0
0 3 3E8 0 408F400000000000 0 0
5 0 0 0 0 0 0
3 0 5 0 0 0 0

// ==== build.f ====
common/fpuPkg.sv
fpuAdd/fpuAddAlign.sv
fpuAdd/fpuAddNorm.sv
design/fpuCsr.sv
design/fpuResultQueue.sv
design/fpuAddUnit.sv
testbench/tbClock.sv
testbench/fpuAddUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
# compile and run the FP add unit testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpuAddUnitTb -f build.f \
	--Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	exit 1
fi
exit 0

// ==== testbench/fpuAddUnitTb.sv ====
// ------------------------------
// fpuAddUnitTb
// trace driven testbench for the FP add unit
// ------------------------------

`timescale 1ns/10ps

module fpuAddUnitTb;

	localparam int QueueDepth = 4;
	localparam int WaitLimit = 200;

	logic clock;
	logic rstN;
	logic reqValid;
	fpuPkg::fpuReqS req;
	logic resultTake;
	logic csrWrite;
	fpuPkg::csrAddrE csrAddr;
	logic [31:0] csrWData;
	logic resultValid;
	fpuPkg::fpuResS result;
	logic creditReturn;
	logic [31:0] csrRData;

	int errors = 0;
	int checks = 0;
	int credits = QueueDepth;
	int seed = 32'h948b_fee4;
	logic holdTake = 1'b0;
	logic creditInHold = 1'b0;
	fpuPkg::fpuResS expQ[$];

	tbClock clockGen0
	(
		.clock(clock),
		.rstN(rstN)
	);

	fpuAddUnit #(.QueueDepth(QueueDepth)) dut0
	(
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.resultTake(resultTake),
		.csrWrite(csrWrite),
		.csrAddr(csrAddr),
		.csrWData(csrWData),
		.resultValid(resultValid),
		.result(result),
		.creditReturn(creditReturn),
		.csrRData(csrRData)
	);

	task automatic compareValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic abortRun(input string what);
		$display("timeout: %s", what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	// credits come back one per creditReturn pulse
	always @(posedge clock)
	begin
		if (creditReturn)
		begin
			credits++;
			if (holdTake)
				creditInHold = 1'b1;
		end
	end

	// collector, pops in order with random gaps
	initial
	begin
		fpuPkg::fpuResS exp;
		resultTake = 1'b0;
		forever
		begin
			@(posedge clock);
			#1;
			resultTake = 1'b0;
			if (rstN && resultValid && !holdTake && (($random(seed) & 3) != 0))
			begin
				if (expQ.size() == 0)
				begin
					errors++;
					$display("a result arrived that no request asked for");
				end
				else
				begin
					exp = expQ.pop_front();
					compareValue("result.value", result.value, exp.value);
					compareValue("result.underflow", 64'(result.underflow), 64'(exp.underflow));
					compareValue("result.cancel", 64'(result.cancel), 64'(exp.cancel));
				end
				resultTake = 1'b1;
			end
		end
	end

	task automatic issueRequest(input logic [1:0] op, input logic [63:0] rn,
		input logic [63:0] rm, input fpuPkg::fpuResS exp);
		int timer;
		timer = 0;
		while (credits == 0)
		begin
			step();
			timer++;
			if (timer == WaitLimit)
				abortRun("no credit came back for a request");
		end
		reqValid = 1'b1;
		req = '{op: fpuPkg::fpuOpE'(op), rn: rn, rm: rm};
		credits--;
		expQ.push_back(exp);
		step();
		reqValid = 1'b0;
	endtask

	// all results out and all credits home
	task automatic drainAll();
		int timer;
		timer = 0;
		while (expQ.size() != 0 || credits != QueueDepth)
		begin
			step();
			timer++;
			if (timer == WaitLimit)
				abortRun("results or credits did not come back");
		end
	endtask

	task automatic checkLatency();
		int cycles;
		fpuPkg::fpuResS exp;
		compareValue("resultValid", 64'(resultValid), 64'd0);
		compareValue("creditReturn", 64'(creditReturn), 64'd0);
		exp = '{value: 64'h4000000000000000, underflow: 1'b0, cancel: 1'b0};
		reqValid = 1'b1;
		req = '{op: fpuPkg::opAdd, rn: 64'h3FF0000000000000, rm: 64'h3FF0000000000000};
		credits--;
		expQ.push_back(exp);
		@(posedge clock);
		#1;
		reqValid = 1'b0;
		cycles = 0;
		while (!resultValid)
		begin
			step();
			cycles++;
			if (cycles == WaitLimit)
				abortRun("the first result never showed up");
		end
		compareValue("latency", 64'(cycles), 64'd4);
		drainAll();
	endtask

	task automatic checkStatus(input logic [63:0] expected, input logic [63:0] clear);
		csrAddr = fpuPkg::csrStatus;
		step();
		compareValue("csrRData", 64'(csrRData), expected);
		if (clear != 0)
		begin
			csrWrite = 1'b1;
			csrWData = clear[31:0];
			step();
			csrWrite = 1'b0;
			compareValue("csrRData", 64'(csrRData), expected & ~clear);
		end
	endtask

	task automatic writeControl(input logic [63:0] data);
		csrAddr = fpuPkg::csrControl;
		csrWrite = 1'b1;
		csrWData = data[31:0];
		step();
		csrWrite = 1'b0;
		compareValue("roundEnable", 64'(csrRData[0]), 64'(data[0]));
	endtask

	initial
	begin
		int fd;
		int timer;
		int n;
		int lastErrors;
		string line;
		logic [3:0] kind;
		logic [1:0] op;
		logic [63:0] rn;
		logic [63:0] rm;
		logic [63:0] expValue;
		logic expUf;
		logic expCancel;

		reqValid = 1'b0;
		req = '{op: fpuPkg::opNone, rn: 64'd0, rm: 64'd0};
		csrWrite = 1'b0;
		csrAddr = fpuPkg::csrControl;
		csrWData = 32'd0;
		lastErrors = 0;

		timer = 0;
		while (rstN !== 1'b1)
		begin
			#1;
			timer++;
			if (timer == WaitLimit)
				abortRun("reset was never released");
		end
		step();

		checkLatency();
		$display("test 6 finished with %0d errors", errors - lastErrors);
		lastErrors = errors;

		fd = $fopen("testbench/fpuAddTrace.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the trace file");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%h %h %h %h %h %h %h", kind, op, rn, rm,
					expValue, expUf, expCancel);
				if (n != 7)
				begin
					errors++;
					$display("a trace line could not be read: %s", line);
					continue;
				end
				case (kind)
					4'd0: issueRequest(op, rn, rm,
						'{value: expValue, underflow: expUf, cancel: expCancel});
					4'd1: writeControl(rn);
					4'd2: checkStatus(rn, rm);
					4'd3:
					begin
						drainAll();
						// id 0 is a pause inside a test
						if (rn != 0)
						begin
							$display("test %0d finished with %0d errors", rn, errors - lastErrors);
							lastErrors = errors;
						end
					end
					4'd4: holdTake = 1'b1;
					4'd5:
					begin
						// requests land 4 cycles after issue
						repeat (6) step();
						compareValue("credits", 64'(credits), 64'd0);
						compareValue("creditReturn in hold", 64'(creditInHold), 64'd0);
						compareValue("resultValid", 64'(resultValid), 64'd1);
						holdTake = 1'b0;
					end
					default:
					begin
						errors++;
						$display("unknown trace line kind %h", kind);
					end
				endcase
			end
			$fclose(fd);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== testbench/tbClock.sv ====
// ------------------------------
// tbClock
// testbench clock and reset
// ------------------------------

`timescale 1ns/10ps

module tbClock
#(
	parameter realtime HalfPeriod = 4ns,
	parameter int ResetCycles = 3
)
(
	output logic clock,
	output logic rstN
);

	initial
	begin
		clock = 1'b0;
		forever
			#(HalfPeriod) clock = ~clock;
	end

	// release a little after the last reset edge
	initial
	begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		#1;
		rstN = 1'b1;
	end

endmodule

// ==== design/fpuAddUnit.sv ====
// ------------------------------
// fpuAddUnit
// FP add pipeline with CSR block
// and credit-paced result queue
// ------------------------------

`timescale 1ns/10ps

module fpuAddUnit
#(
	parameter int QueueDepth = fpuPkg::QueueDepthDefault
)
(
	input logic clock,
	input logic rstN,
	input logic reqValid,
	input fpuPkg::fpuReqS req,
	input logic resultTake,
	input logic csrWrite,
	input fpuPkg::csrAddrE csrAddr,
	input logic [31:0] csrWData,
	output logic resultValid,
	output fpuPkg::fpuResS result,
	output logic creditReturn,
	output logic [31:0] csrRData
);

	fpuPkg::fpuMidS mid;
	fpuPkg::fpuResS res;
	logic resValid;
	logic roundEnable;

	fpuAddAlign align0
	(
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.req(req),
		.mid(mid)
	);

	fpuAddNorm norm0
	(
		.clock(clock),
		.rstN(rstN),
		.mid(mid),
		.roundEnable(roundEnable),
		.resValid(resValid),
		.res(res)
	);

	fpuCsr csr0
	(
		.clock(clock),
		.rstN(rstN),
		.csrWrite(csrWrite),
		.csrAddr(csrAddr),
		.csrWData(csrWData),
		.resValid(resValid),
		.res(res),
		.csrRData(csrRData),
		.roundEnable(roundEnable)
	);

	fpuResultQueue #(.QueueDepth(QueueDepth)) queue0
	(
		.clock(clock),
		.rstN(rstN),
		.writeValid(resValid),
		.writeData(res),
		.resultTake(resultTake),
		.resultValid(resultValid),
		.result(result),
		.creditReturn(creditReturn)
	);

endmodule

// ==== design/fpuResultQueue.sv ====
// ------------------------------
// fpuResultQueue
// result FIFO, one credit back per pop
// ------------------------------

`timescale 1ns/10ps

module fpuResultQueue
#(
	parameter int QueueDepth = fpuPkg::QueueDepthDefault
)
(
	input logic clock,
	input logic rstN,
	input logic writeValid,
	input fpuPkg::fpuResS writeData,
	input logic resultTake,
	output logic resultValid,
	output fpuPkg::fpuResS result,
	output logic creditReturn
);

	localparam int PtrW = $clog2(QueueDepth);

	fpuPkg::fpuResS mem [QueueDepth];
	logic [PtrW-1:0] readPtr;
	logic [PtrW-1:0] writePtr;
	logic [PtrW:0] count;
	logic pop;

	assign resultValid = (count != '0);
	assign result = mem[readPtr];
	assign pop = resultTake && resultValid;

	always_ff @(posedge clock)
	begin
		if (writeValid)
			mem[writePtr] <= writeData;
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (writeValid)
				writePtr <= writePtr + 1'b1;
			if (pop)
				readPtr <= readPtr + 1'b1;
			count <= count + (PtrW + 1)'(writeValid) - (PtrW + 1)'(pop);
			creditReturn <= pop;
		end
	end

	// the issuer sent without a credit
	assert property (@(posedge clock) disable iff (!rstN)
		writeValid |-> (count < QueueDepth))
		else $error("fpuResultQueue: write into a full queue");

	assert property (@(posedge clock) disable iff (!rstN)
		resultTake |-> resultValid)
		else $error("fpuResultQueue: take while the queue is empty");

endmodule

// ==== design/fpuCsr.sv ====
// ------------------------------
// fpuCsr
// round enable and sticky status flags
// ------------------------------

`timescale 1ns/10ps

module fpuCsr
(
	input logic clock,
	input logic rstN,
	input logic csrWrite,
	input fpuPkg::csrAddrE csrAddr,
	input logic [31:0] csrWData,
	input logic resValid,
	input fpuPkg::fpuResS res,
	output logic [31:0] csrRData,
	output logic roundEnable
);

	logic underflowFlag;
	logic cancelFlag;
	logic [1:0] clearMask;
	logic [1:0] setMask;

	// write-one-to-clear on the status word
	assign clearMask = (csrWrite && (csrAddr == fpuPkg::csrStatus)) ? csrWData[1:0] : 2'b00;
	assign setMask = resValid ? {res.cancel, res.underflow} : 2'b00;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			roundEnable <= 1'b1;
			underflowFlag <= 1'b0;
			cancelFlag <= 1'b0;
		end
		else
		begin
			if (csrWrite && (csrAddr == fpuPkg::csrControl))
				roundEnable <= csrWData[0];
			// a new flag beats a clear in the same cycle
			underflowFlag <= (underflowFlag & ~clearMask[fpuPkg::StatusUnderflowBit]) |
				setMask[fpuPkg::StatusUnderflowBit];
			cancelFlag <= (cancelFlag & ~clearMask[fpuPkg::StatusCancelBit]) |
				setMask[fpuPkg::StatusCancelBit];
		end
	end

	always_comb
	begin
		csrRData = 32'd0;
		if (csrAddr == fpuPkg::csrControl)
			csrRData[0] = roundEnable;
		else
		begin
			csrRData[fpuPkg::StatusUnderflowBit] = underflowFlag;
			csrRData[fpuPkg::StatusCancelBit] = cancelFlag;
		end
	end

endmodule

// ==== fpuAdd/fpuAddNorm.sv ====
// ------------------------------
// fpuAddNorm
// normalize, round, flush and pack
// the double result
// ------------------------------

`timescale 1ns/10ps

module fpuAddNorm
(
	input logic clock,
	input logic rstN,
	input fpuPkg::fpuMidS mid,
	input logic roundEnable,
	output logic resValid,
	output fpuPkg::fpuResS res
);

	logic hit;
	logic [5:0] coarseShift;
	logic coarseSign;
	logic coarseCancel;
	logic [11:0] coarseExp;
	logic [63:0] coarseFrac;

	logic s3Valid;
	logic s3Sign;
	logic s3Cancel;
	logic [11:0] s3Exp;
	logic [63:0] s3Frac;

	logic [3:0] fineShift;
	logic [11:0] fineExp;
	logic [63:0] fineFrac;
	fpuPkg::fpuResS nextRes;

	// stage 3, coarse normalization in byte steps
	always_comb
	begin
		coarseShift = 6'd0;
		// lowest window wins last, so scan from the bottom up
		for (int k = 7; k >= 0; k--)
		begin
			if (k == 7)
				hit = (mid.fraction != 64'd0);
			else
				hit = ((mid.fraction >> (54 - 8 * k)) != 64'd0);
			if (hit)
				coarseShift = 6'(8 * k);
		end

		coarseSign = mid.sign;
		coarseCancel = 1'b0;
		if (mid.fraction[63])
		begin
			// carry out of the add
			coarseExp = {1'b0, mid.exponent} + 12'd1;
			coarseFrac = mid.fraction >> 1;
		end
		else if (mid.fraction == 64'd0)
		begin
			coarseSign = 1'b0;
			coarseCancel = 1'b1;
			coarseExp = 12'd0;
			coarseFrac = 64'd0;
		end
		else
		begin
			coarseExp = {1'b0, mid.exponent} - {6'd0, coarseShift};
			coarseFrac = mid.fraction << coarseShift;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			s3Valid <= 1'b0;
		else
			s3Valid <= mid.valid;
	end

	always_ff @(posedge clock)
	begin
		s3Sign <= coarseSign;
		s3Cancel <= coarseCancel;
		s3Exp <= coarseExp;
		s3Frac <= coarseFrac;
	end

	// stage 4, put the leading one on bit 62
	always_comb
	begin
		fineShift = 4'd8;
		for (int i = 0; i < 8; i++)
		begin
			if (s3Frac[55 + i])
				fineShift = 4'(7 - i);
		end
		fineFrac = s3Frac << fineShift;
		fineExp = s3Exp - {8'd0, fineShift};

		nextRes.underflow = 1'b0;
		nextRes.cancel = s3Cancel;
		if (s3Cancel)
			nextRes.value = 64'd0;
		else if (fineExp[11])
		begin
			// exponent went negative, flush to +0
			nextRes.value = 64'd0;
			nextRes.underflow = 1'b1;
		end
		else
		begin
			// round half up on the first dropped bit
			nextRes.value = {s3Sign, fineExp[10:0], fineFrac[61:10]} +
				{63'd0, roundEnable & fineFrac[9]};
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			resValid <= 1'b0;
		else
			resValid <= s3Valid;
	end

	always_ff @(posedge clock)
	begin
		res <= nextRes;
	end

	// overflow is not handled, so an all-ones exponent means bad operands
	assert property (@(posedge clock) disable iff (!rstN)
		resValid |-> (res.value[62:52] != 11'h7ff))
		else $error("fpuAddNorm: result exponent is all ones");

endmodule

// ==== fpuAdd/fpuAddAlign.sv ====
// ------------------------------
// fpuAddAlign
// unpack, swap and align operands,
// then add/sub fractions or load integer
// ------------------------------

`timescale 1ns/10ps

module fpuAddAlign
(
	input logic clock,
	input logic rstN,
	input logic reqValid,
	input fpuPkg::fpuReqS req,
	output fpuPkg::fpuMidS mid
);

	logic sgnA;
	logic sgnB;
	logic [10:0] expA;
	logic [10:0] expB;
	logic [63:0] fraA;
	logic [63:0] fraB;
	logic [11:0] diffAB;
	logic [11:0] diffBA;
	logic [63:0] fraAShifted;
	logic [63:0] fraBShifted;

	logic s1Valid;
	fpuPkg::fpuOpE s1Op;
	logic s1SgnA;
	logic s1SgnB;
	logic [10:0] s1Exp;
	logic [63:0] s1FraA;
	logic [63:0] s1FraB;
	logic [63:0] s1Int;

	logic sumSign;
	logic [10:0] sumExp;
	logic [63:0] sumFrac;

	logic midValid;
	logic midSign;
	logic [10:0] midExp;
	logic [63:0] midFrac;

	// stage 1, unpack with hidden bit and 10 guard bits
	always_comb
	begin
		sgnA = req.rn[63];
		sgnB = req.rm[63] ^ (req.op == fpuPkg::opSub);
		expA = req.rn[62:52];
		expB = req.rm[62:52];
		fraA = {1'b0, (expA != 11'd0), req.rn[51:0], 10'h0};
		fraB = {1'b0, (expB != 11'd0), req.rm[51:0], 10'h0};
		diffAB = {1'b0, expA} - {1'b0, expB};
		diffBA = {1'b0, expB} - {1'b0, expA};
		// gaps beyond the fraction width shift out to zero
		fraAShifted = (diffBA <= 12'd52) ? (fraA >> diffBA[5:0]) : 64'd0;
		fraBShifted = (diffAB <= 12'd52) ? (fraB >> diffAB[5:0]) : 64'd0;
	end

	// opNone issues are dropped here
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			s1Valid <= 1'b0;
		else
			s1Valid <= reqValid && (req.op != fpuPkg::opNone);
	end

	// larger exponent always leads
	always_ff @(posedge clock)
	begin
		s1Op <= req.op;
		s1Int <= req.rn;
		if (expA >= expB)
		begin
			s1SgnA <= sgnA;
			s1SgnB <= sgnB;
			s1Exp <= expA;
			s1FraA <= fraA;
			s1FraB <= fraBShifted;
		end
		else
		begin
			s1SgnA <= sgnB;
			s1SgnB <= sgnA;
			s1Exp <= expB;
			s1FraA <= fraB;
			s1FraB <= fraAShifted;
		end
	end

	// stage 2
	always_comb
	begin
		if (s1Op == fpuPkg::opIntToFloat)
		begin
			// integer sits with its LSB at 2^0, so bit 62 weighs 2^(1085-1023)
			sumSign = s1Int[63];
			sumExp = 11'd1085;
			sumFrac = s1Int[63] ? -s1Int : s1Int;
		end
		else
		begin
			sumSign = s1SgnA;
			sumExp = s1Exp;
			sumFrac = (s1SgnA == s1SgnB) ? (s1FraA + s1FraB) : (s1FraA - s1FraB);
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			midValid <= 1'b0;
		else
			midValid <= s1Valid;
	end

	always_ff @(posedge clock)
	begin
		midSign <= sumSign;
		midExp <= sumExp;
		midFrac <= sumFrac;
	end

	assign mid = '{valid: midValid, sign: midSign, exponent: midExp, fraction: midFrac};

endmodule

// ==== common/fpuPkg.sv ====
// ------------------------------
// fpuPkg
// shared types for the FP add unit,
// opcodes, pipeline payloads, CSR map
// ------------------------------

package fpuPkg;

	// opcode encoding follows the execute stage
	typedef enum logic [1:0]
	{
		opNone = 2'd0,
		opAdd = 2'd1,
		opSub = 2'd2,
		opIntToFloat = 2'd3
	} fpuOpE;

	// issued request, rn is also the integer source
	typedef struct packed
	{
		fpuOpE op;
		logic [63:0] rn;
		logic [63:0] rm;
	} fpuReqS;

	// align half to norm half
	typedef struct packed
	{
		logic valid;
		logic sign;
		logic [10:0] exponent;
		logic [63:0] fraction;
	} fpuMidS;

	// one queue entry
	typedef struct packed
	{
		logic [63:0] value;
		logic underflow;
		logic cancel;
	} fpuResS;

	// register port addresses
	typedef enum logic
	{
		csrControl = 1'b0,
		csrStatus = 1'b1
	} csrAddrE;

	// bit positions in csrStatus
	localparam int StatusUnderflowBit = 0;
	localparam int StatusCancelBit = 1;

	// default result queue depth, also the issuer's credit count
	localparam int QueueDepthDefault = 4;

endpackage
